// File: rtl/lc3b_pkg.sv
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [1:0] lc3b_mem_wmask;

    // all-zero instruction is BR with nzp 000, used as the pipeline bubble
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass
    } lc3b_aluop;

    // alu input a source
    typedef enum logic [1:0] {
        amux_reg,
        amux_pc
    } alumux1_sel_t;

    // alu input b source
    typedef enum logic [1:0] {
        bmux_reg,
        bmux_imm,
        bmux_offset
    } alumux2_sel_t;

    typedef enum logic [1:0] {
        imm_imm5,
        imm_off6,
        imm_shift
    } imm_sel_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef struct packed {
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        lc3b_aluop aluop;
        logic mem_read;
        logic mem_write;
        logic byte_op;
        logic load_regfile;
        logic load_cc;
        logic wb_sel;           // 1 selects load data
        logic is_branch;
        logic is_jmp;
        logic [2:0] dest;       // nzp bits for BR
    } ctrl_t;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word opa;
        lc3b_word opb;
        logic [2:0] sr1;
        logic [2:0] sr2;
        lc3b_word imm;
        lc3b_word offset;
        ctrl_t ctrl;
    } id_ex_t;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word alu;
        lc3b_word wdata;
        ctrl_t ctrl;
    } ex_mem_t;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word alu;
        lc3b_word rdata;
        ctrl_t ctrl;
    } mem_wb_t;

endpackage

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile
(
    input logic clk,
    input logic rst,
    input logic load,
    input logic [2:0] dest,
    input lc3b_pkg::lc3b_word in,
    input logic [2:0] src_a,
    input logic [2:0] src_b,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);
    import lc3b_pkg::*;

    lc3b_word regs [8];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (load)
        begin
            regs[dest] <= in;
        end
    end

    // write-through so WB feeds ID in the same cycle
    assign reg_a = (load && dest == src_a) ? in : regs[src_a];
    assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu
(
    input lc3b_pkg::lc3b_aluop aluop,
    input lc3b_pkg::lc3b_word a,
    input lc3b_pkg::lc3b_word b,
    output lc3b_pkg::lc3b_word f
);
    import lc3b_pkg::*;

    logic [3:0] shamt;

    // shift amount comes from the low nibble only
    assign shamt = b[3:0];

    always_comb
    begin
        case (aluop)
            alu_add:  f = a + b;
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            alu_sll:  f = a << shamt;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = $signed(a) >>> shamt;
            alu_pass: f = a;
            default:  f = a;
        endcase
    end

endmodule

// File: rtl/decode.sv
`timescale 1ns/1ps

module decode
(
    input lc3b_pkg::lc3b_word instruction,
    output lc3b_pkg::ctrl_t ctrl,
    output logic [2:0] sr1,
    output logic [2:0] sr2,
    output lc3b_pkg::imm_sel_t imm_sel
);
    import lc3b_pkg::*;

    lc3b_opcode opcode;

    assign opcode = lc3b_opcode'(instruction[15:12]);

    always_comb
    begin
        ctrl = '0;
        ctrl.dest = instruction[11:9];
        sr1 = instruction[8:6];
        sr2 = instruction[2:0];
        imm_sel = imm_imm5;

        case (opcode)
            op_add, op_and:
            begin
                ctrl.aluop = (opcode == op_add) ? alu_add : alu_and;
                ctrl.alumux2_sel = instruction[5] ? bmux_imm : bmux_reg;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_not:
            begin
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_shf:
            begin
                imm_sel = imm_shift;
                ctrl.alumux2_sel = bmux_imm;
                // bit 4 picks direction, bit 5 arithmetic right
                if (!instruction[4])
                    ctrl.aluop = alu_sll;
                else if (instruction[5])
                    ctrl.aluop = alu_sra;
                else
                    ctrl.aluop = alu_srl;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_ldr, op_ldb:
            begin
                imm_sel = imm_off6;
                ctrl.alumux2_sel = bmux_imm;
                ctrl.mem_read = 1'b1;
                ctrl.byte_op = (opcode == op_ldb);
                ctrl.wb_sel = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_str, op_stb:
            begin
                // store data register sits in the dest field
                sr2 = instruction[11:9];
                imm_sel = imm_off6;
                ctrl.alumux2_sel = bmux_imm;
                ctrl.mem_write = 1'b1;
                ctrl.byte_op = (opcode == op_stb);
            end
            op_lea:
            begin
                ctrl.alumux1_sel = amux_pc;
                ctrl.alumux2_sel = bmux_offset;
                ctrl.load_regfile = 1'b1;
            end
            op_br:
            begin
                ctrl.alumux1_sel = amux_pc;
                ctrl.alumux2_sel = bmux_offset;
                ctrl.is_branch = 1'b1;
            end
            op_jmp:
            begin
                ctrl.aluop = alu_pass;
                ctrl.is_jmp = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
(
    input logic [2:0] src_a_ex,
    input logic [2:0] src_b_ex,
    input logic [2:0] dest_mem,
    input logic load_regfile_mem,
    input logic mem_read_mem,
    input logic [2:0] dest_wb,
    input logic load_regfile_wb,
    output lc3b_pkg::fwd_sel_t fwd_a,
    output lc3b_pkg::fwd_sel_t fwd_b,
    output logic load_stall
);
    import lc3b_pkg::*;

    logic hit_mem_a;
    logic hit_mem_b;

    // youngest producer wins
    function automatic fwd_sel_t pick_source(
        input logic [2:0] src,
        input logic [2:0] d_mem,
        input logic ld_mem,
        input logic [2:0] d_wb,
        input logic ld_wb
    );
        fwd_sel_t sel;
        sel = fwd_none;
        if (ld_mem && d_mem == src)
            sel = fwd_mem;
        else if (ld_wb && d_wb == src)
            sel = fwd_wb;
        return sel;
    endfunction

    assign fwd_a = pick_source(src_a_ex, dest_mem, load_regfile_mem, dest_wb, load_regfile_wb);
    assign fwd_b = pick_source(src_b_ex, dest_mem, load_regfile_mem, dest_wb, load_regfile_wb);

    assign hit_mem_a = load_regfile_mem && dest_mem == src_a_ex;
    assign hit_mem_b = load_regfile_mem && dest_mem == src_b_ex;

    // load data only exists in WB, so hold the consumer one cycle
    assign load_stall = mem_read_mem & (hit_mem_a | hit_mem_b);

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ps

module datapath
#(
    parameter lc3b_pkg::lc3b_word reset_pc = 16'h0000
)
(
    input logic clk,
    input logic rst,
    output logic imem_read,
    output lc3b_pkg::lc3b_word imem_address,
    input logic imem_resp,
    input lc3b_pkg::lc3b_word imem_rdata,
    output logic dmem_read,
    output logic dmem_write,
    output lc3b_pkg::lc3b_word dmem_address,
    output lc3b_pkg::lc3b_word dmem_wdata,
    output lc3b_pkg::lc3b_mem_wmask dmem_byte_enable,
    input logic dmem_resp,
    input lc3b_pkg::lc3b_word dmem_rdata
);
    import lc3b_pkg::*;

    lc3b_word pc;
    lc3b_word pc_plus2;
    logic fetch_valid;
    lc3b_word fetch_ir;
    lc3b_word if_instr;
    logic stall_i;
    logic stall_d;
    logic load_stall;
    logic adv_front;
    logic adv_back;

    lc3b_word ir_id;
    lc3b_word pc_id;
    ctrl_t ctrl_id;
    logic [2:0] sr1_id;
    logic [2:0] sr2_id;
    imm_sel_t imm_sel_id;
    lc3b_word reg_a_id;
    lc3b_word reg_b_id;
    lc3b_word imm_id;
    lc3b_word offset_id;

    id_ex_t id_ex;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    lc3b_word opa_fwd;
    lc3b_word opb_fwd;
    lc3b_word alu_a;
    lc3b_word alu_b;
    lc3b_word alu_f;

    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic [7:0] load_byte;
    lc3b_word load_val;
    lc3b_word wb_data;
    logic [2:0] cc;
    logic [2:0] cc_next;
    logic br_taken;

    function automatic lc3b_word fwd_pick(
        input fwd_sel_t sel,
        input lc3b_word reg_val,
        input lc3b_word mem_val,
        input lc3b_word wb_val
    );
        lc3b_word val;
        case (sel)
            fwd_mem: val = mem_val;
            fwd_wb:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    // a response alone does not end a memory stall for the other port
    assign stall_i = imem_read & ~imem_resp;
    assign stall_d = (dmem_read | dmem_write) & ~dmem_resp;
    assign adv_back = ~stall_i & ~stall_d;
    assign adv_front = adv_back & ~load_stall;

    // fetch; buffer holds an instruction that arrived while the front was held
    assign pc_plus2 = pc + 16'd2;
    assign imem_address = pc;
    assign imem_read = ~fetch_valid & ~br_taken;
    assign if_instr = fetch_valid ? fetch_ir : imem_rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= reset_pc;
            fetch_valid <= 1'b0;
        end
        else if (br_taken)
        begin
            pc <= mem_wb.alu;
            fetch_valid <= 1'b0;
        end
        else if (adv_front)
        begin
            pc <= pc_plus2;
            fetch_valid <= 1'b0;
        end
        else if (imem_read && imem_resp)
        begin
            fetch_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (imem_read && imem_resp)
            fetch_ir <= imem_rdata;
        if (adv_front)
            pc_id <= pc_plus2;
    end

    always_ff @(posedge clk)
    begin
        if (rst || br_taken)
            ir_id <= '0;
        else if (adv_front)
            ir_id <= if_instr;
    end

    // decode and register read
    decode u_decode
    (
        .instruction(ir_id),
        .ctrl(ctrl_id),
        .sr1(sr1_id),
        .sr2(sr2_id),
        .imm_sel(imm_sel_id)
    );

    regfile u_regfile
    (
        .clk(clk),
        .rst(rst),
        .load(mem_wb.ctrl.load_regfile),
        .dest(mem_wb.ctrl.dest),
        .in(wb_data),
        .src_a(sr1_id),
        .src_b(sr2_id),
        .reg_a(reg_a_id),
        .reg_b(reg_b_id)
    );

    always_comb
    begin
        case (imm_sel_id)
            imm_off6:
                // word accesses scale the offset by two
                imm_id = ctrl_id.byte_op ? {{10{ir_id[5]}}, ir_id[5:0]}
                                         : {{9{ir_id[5]}}, ir_id[5:0], 1'b0};
            imm_shift: imm_id = {12'b0, ir_id[3:0]};
            default:   imm_id = {{11{ir_id[4]}}, ir_id[4:0]};
        endcase
    end

    assign offset_id = {{6{ir_id[8]}}, ir_id[8:0], 1'b0};

    always_ff @(posedge clk)
    begin
        if (rst || br_taken)
        begin
            id_ex <= '0;
        end
        else if (adv_front)
        begin
            id_ex <= '{pc: pc_id, opa: reg_a_id, opb: reg_b_id, sr1: sr1_id, sr2: sr2_id,
                       imm: imm_id, offset: offset_id, ctrl: ctrl_id};
        end
        else if (adv_back)
        begin
            // load-use hold; the WB producer leaves, so keep what it forwarded
            id_ex.opa <= opa_fwd;
            id_ex.opb <= opb_fwd;
        end
    end

    // execute
    hazard_unit u_hazard
    (
        .src_a_ex(id_ex.sr1),
        .src_b_ex(id_ex.sr2),
        .dest_mem(ex_mem.ctrl.dest),
        .load_regfile_mem(ex_mem.ctrl.load_regfile),
        .mem_read_mem(ex_mem.ctrl.mem_read),
        .dest_wb(mem_wb.ctrl.dest),
        .load_regfile_wb(mem_wb.ctrl.load_regfile),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .load_stall(load_stall)
    );

    assign opa_fwd = fwd_pick(fwd_a, id_ex.opa, ex_mem.alu, wb_data);
    assign opb_fwd = fwd_pick(fwd_b, id_ex.opb, ex_mem.alu, wb_data);
    assign alu_a = (id_ex.ctrl.alumux1_sel == amux_pc) ? id_ex.pc : opa_fwd;

    always_comb
    begin
        case (id_ex.ctrl.alumux2_sel)
            bmux_imm:    alu_b = id_ex.imm;
            bmux_offset: alu_b = id_ex.offset;
            default:     alu_b = opb_fwd;
        endcase
    end

    alu u_alu
    (
        .aluop(id_ex.ctrl.aluop),
        .a(alu_a),
        .b(alu_b),
        .f(alu_f)
    );

    always_ff @(posedge clk)
    begin
        if (rst || br_taken || (adv_back && load_stall))
            ex_mem <= '0;
        else if (adv_back)
            ex_mem <= '{pc: id_ex.pc, alu: alu_f, wdata: opb_fwd, ctrl: id_ex.ctrl};
    end

    // memory access; a taken branch in WB squashes the request
    assign dmem_read = ex_mem.ctrl.mem_read & ~br_taken;
    assign dmem_write = ex_mem.ctrl.mem_write & ~br_taken;
    assign dmem_address = {ex_mem.alu[15:1], ex_mem.alu[0] & ex_mem.ctrl.byte_op};
    assign dmem_wdata = ex_mem.ctrl.byte_op ? {ex_mem.wdata[7:0], ex_mem.wdata[7:0]}
                                            : ex_mem.wdata;

    always_comb
    begin
        if (!ex_mem.ctrl.byte_op)
            dmem_byte_enable = 2'b11;
        else if (ex_mem.alu[0])
            dmem_byte_enable = 2'b10;
        else
            dmem_byte_enable = 2'b01;
    end

    always_ff @(posedge clk)
    begin
        if (rst || br_taken)
            mem_wb <= '0;
        else if (adv_back)
            mem_wb <= '{pc: ex_mem.pc, alu: ex_mem.alu, rdata: dmem_rdata, ctrl: ex_mem.ctrl};
    end

    // writeback, cc and branch resolution
    assign load_byte = mem_wb.alu[0] ? mem_wb.rdata[15:8] : mem_wb.rdata[7:0];
    assign load_val = mem_wb.ctrl.byte_op ? {{8{load_byte[7]}}, load_byte} : mem_wb.rdata;
    assign wb_data = mem_wb.ctrl.wb_sel ? load_val : mem_wb.alu;

    assign cc_next[2] = wb_data[15];
    assign cc_next[1] = (wb_data == '0);
    assign cc_next[0] = ~wb_data[15] & (wb_data != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
            cc <= 3'b010;
        else if (mem_wb.ctrl.load_cc)
            cc <= cc_next;
    end

    assign br_taken = mem_wb.ctrl.is_jmp | (mem_wb.ctrl.is_branch & |(mem_wb.ctrl.dest & cc));

endmodule

// File: rtl/lc3b_cpu.sv
`timescale 1ns/1ps

module lc3b_cpu
#(
    parameter lc3b_pkg::lc3b_word reset_pc = 16'h0000
)
(
    input logic clk,
    input logic rst,
    output logic imem_read,
    output lc3b_pkg::lc3b_word imem_address,
    input logic imem_resp,
    input lc3b_pkg::lc3b_word imem_rdata,
    output logic dmem_read,
    output logic dmem_write,
    output lc3b_pkg::lc3b_word dmem_address,
    output lc3b_pkg::lc3b_word dmem_wdata,
    output lc3b_pkg::lc3b_mem_wmask dmem_byte_enable,
    input logic dmem_resp,
    input lc3b_pkg::lc3b_word dmem_rdata
);

    datapath #(
        .reset_pc(reset_pc)
    ) u_datapath (
        .clk(clk),
        .rst(rst),
        .imem_read(imem_read),
        .imem_address(imem_address),
        .imem_resp(imem_resp),
        .imem_rdata(imem_rdata),
        .dmem_read(dmem_read),
        .dmem_write(dmem_write),
        .dmem_address(dmem_address),
        .dmem_wdata(dmem_wdata),
        .dmem_byte_enable(dmem_byte_enable),
        .dmem_resp(dmem_resp),
        .dmem_rdata(dmem_rdata)
    );

endmodule

// File: bench/tb_lc3b_asserts.sv
`timescale 1ns/1ps

module tb_lc3b_asserts
(
    input logic clk,
    input logic rst,
    input logic imem_read,
    input logic imem_resp,
    input lc3b_pkg::lc3b_word imem_address,
    input logic dmem_read,
    input logic dmem_write,
    input logic dmem_resp,
    input lc3b_pkg::lc3b_word dmem_address,
    input logic br_taken
);

    no_read_and_write: assert property (@(posedge clk) !(dmem_read && dmem_write))
        else $error("data port read and write high together");

    // a pending request is held until its response
    imem_hold: assert property (@(posedge clk) disable iff (rst)
        imem_read && !imem_resp |=> imem_read && $stable(imem_address))
        else $error("instruction request changed before its response");

    dmem_hold: assert property (@(posedge clk) disable iff (rst)
        (dmem_read || dmem_write) && !dmem_resp |=>
            $stable(dmem_read) && $stable(dmem_write) && $stable(dmem_address))
        else $error("data request changed before its response");

    // the bubbles behind a taken branch make no memory access and no redirect
    flush_bubbles: assert property (@(posedge clk) disable iff (rst)
        $past(br_taken) || $past(br_taken, 2) || $past(br_taken, 3)
            |-> !dmem_read && !dmem_write && !br_taken)
        else $error("memory access or branch in the bubbles after a taken branch");

    reset_no_write: assert property (@(posedge clk) rst |=> !dmem_write)
        else $error("data write during reset");

endmodule

bind datapath tb_lc3b_asserts u_asserts
(
    .clk(clk),
    .rst(rst),
    .imem_read(imem_read),
    .imem_resp(imem_resp),
    .imem_address(imem_address),
    .dmem_read(dmem_read),
    .dmem_write(dmem_write),
    .dmem_resp(dmem_resp),
    .dmem_address(dmem_address),
    .br_taken(br_taken)
);

// File: bench/tb_lc3b.sv
`timescale 1ns/1ps

module tb_lc3b;
    import lc3b_pkg::*;

    localparam int mem_words = 256;
    localparam int stim_words = 512;

    logic clk;
    logic rst;
    logic imem_read;
    lc3b_word imem_address;
    logic imem_resp;
    lc3b_word imem_rdata;
    logic dmem_read;
    logic dmem_write;
    lc3b_word dmem_address;
    lc3b_word dmem_wdata;
    lc3b_mem_wmask dmem_byte_enable;
    logic dmem_resp;
    lc3b_word dmem_rdata;

    lc3b_word stim [stim_words];
    lc3b_word imem [mem_words];
    lc3b_word dmem [mem_words];

    int image_words;
    int store_count;
    int loop_address;
    int stores_seen;
    int loop_hits;
    int cycles;
    int cycle_limit;
    int i_wait;
    int i_lat;
    int d_wait;
    int d_lat;

    lc3b_cpu #(
        .reset_pc(16'h0000)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .imem_read(imem_read),
        .imem_address(imem_address),
        .imem_resp(imem_resp),
        .imem_rdata(imem_rdata),
        .dmem_read(dmem_read),
        .dmem_write(dmem_write),
        .dmem_address(dmem_address),
        .dmem_wdata(dmem_wdata),
        .dmem_byte_enable(dmem_byte_enable),
        .dmem_resp(dmem_resp),
        .dmem_rdata(dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at cycle %0d", cycles);
    endtask

    task automatic check_value(input string name, input lc3b_word got, input lc3b_word exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            fail_run($sformatf("mismatch in store %0d", stores_seen));
        end
    endtask

    task automatic load_stimulus();
        $readmemh("bench/lc3b_stimulus.hex", stim);
        image_words = int'(stim[0]);
        store_count = int'(stim[1]);
        loop_address = int'(stim[2]);
        if (image_words <= 0 || image_words > mem_words || store_count <= 0)
            fail_run("stimulus file is missing or has a bad header");
        // background pattern distinct for every word address
        for (int i = 0; i < mem_words; i++)
        begin
            imem[i] = 16'(i) ^ 16'ha5c3;
            dmem[i] = 16'(i) ^ 16'ha5c3;
        end
        for (int i = 0; i < image_words; i++)
        begin
            imem[i] = stim[3 + i];
            dmem[i] = stim[3 + i];
        end
    endtask

    task automatic serve_imem();
        if (!imem_read)
        begin
            imem_resp = 1'b0;
            i_wait = 0;
        end
        else if (i_wait >= i_lat)
        begin
            imem_resp = 1'b1;
            imem_rdata = imem[imem_address[8:1]];
        end
        else
        begin
            imem_resp = 1'b0;
            i_wait++;
        end
    endtask

    task automatic serve_dmem();
        if (!(dmem_read || dmem_write))
        begin
            dmem_resp = 1'b0;
            d_wait = 0;
        end
        else if (d_wait >= d_lat)
        begin
            dmem_resp = 1'b1;
            dmem_rdata = dmem[dmem_address[8:1]];
        end
        else
        begin
            dmem_resp = 1'b0;
            d_wait++;
        end
    endtask

    task automatic check_store();
        int base;
        lc3b_word got_mask;
        lc3b_word exp_mask;
        lc3b_word exp_be;
        if (stores_seen >= store_count)
            fail_run($sformatf("unexpected store to address %h after the last expected one",
                               dmem_address));
        base = 3 + image_words + 3 * stores_seen;
        exp_be = stim[base + 2];
        got_mask = {{8{dmem_byte_enable[1]}}, {8{dmem_byte_enable[0]}}};
        exp_mask = {{8{exp_be[1]}}, {8{exp_be[0]}}};
        check_value("dmem_address", dmem_address, stim[base]);
        check_value("dmem_wdata", dmem_wdata & got_mask, stim[base + 1] & exp_mask);
        check_value("dmem_byte_enable", {14'b0, dmem_byte_enable}, exp_be);
        stores_seen++;
    endtask

    task automatic write_dmem();
        if (dmem_byte_enable[0])
            dmem[dmem_address[8:1]][7:0] = dmem_wdata[7:0];
        if (dmem_byte_enable[1])
            dmem[dmem_address[8:1]][15:8] = dmem_wdata[15:8];
    endtask

    // decides which transfers the next rising edge completes
    task automatic complete_transfers();
        if (imem_read && imem_resp)
        begin
            if (int'(imem_address) == loop_address)
                loop_hits++;
            i_wait = 0;
            i_lat = int'($urandom % 4);
        end
        // a data response only counts when the fetch side is not stalled
        if ((dmem_read || dmem_write) && dmem_resp && !(imem_read && !imem_resp))
        begin
            if (dmem_write)
            begin
                check_store();
                write_dmem();
            end
            d_wait = 0;
            d_lat = int'($urandom % 4);
        end
    endtask

    initial
    begin
        void'($urandom(24));
        rst = 1'b1;
        imem_resp = 1'b0;
        imem_rdata = '0;
        dmem_resp = 1'b0;
        dmem_rdata = '0;
        stores_seen = 0;
        loop_hits = 0;
        cycles = 0;
        i_wait = 0;
        d_wait = 0;
        load_stimulus();
        cycle_limit = 12 * image_words + 4 * store_count + 100;
        i_lat = int'($urandom % 4);
        d_lat = int'($urandom % 4);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // done once every store is seen and the final loop has branched back
        while (stores_seen < store_count || loop_hits < 2)
        begin
            if (cycles >= cycle_limit)
                fail_run($sformatf("timeout: program did not finish in %0d cycles", cycle_limit));
            serve_imem();
            serve_dmem();
            complete_transfers();
            @(negedge clk);
            cycles++;
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: bench/lc3b_stimulus.hex
// header: image word count, expected store count, byte address of the final self-loop
// then the image words, then one store per line: address, data, byte enable
0042 000B 0058
// base pointers and arithmetic
1E25 DFC5 1C21 DD87 123D 1441 75C0 56AC
98FF 79C1 DB33 D714 5B43 7BC2
// loads, load-use, byte loads and byte stores
6380 1461 75C3 2782 77C4 2981 39CB 35CA
// branches on each cc, wrong-path stores in between
0401 71C6 0801 79C7 1220 0A01 0402 79C7
79C7 1227 0201 79C7 73C7
// jmp, forwarding chain, final loop
EA03 C140 79C8 79C8 7BC8 1223 1241 1241
73C9 0FFF
// filler up to the data words at byte 0x0080
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000
8421 12F0
// expected stores
00A0 FFFA 0003
00A2 FFF7 0003
00A4 0FFE 0003
00A6 8422 0003
00A8 FFF0 0003
00AB 8484 0002
00AA 2222 0001
00AC 0000 0003
00AE 0007 0003
00B0 004E 0003
00B2 000C 0003

// File: list.f
rtl/lc3b_pkg.sv
rtl/regfile.sv
rtl/alu.sv
rtl/decode.sv
rtl/hazard_unit.sv
rtl/datapath.sv
rtl/lc3b_cpu.sv
bench/tb_lc3b_asserts.sv
bench/tb_lc3b.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lc3b -f list.f -o sim_lc3b \
    && ./obj_dir/sim_lc3b | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
